//--- sources.f
verilog/video_timing_pkg.sv
verilog/video_pixel_pkg.sv
verilog/raster_timing.sv
verilog/fb_fetch.sv
verilog/pixel_shifter.sv
verilog/video_top.sv
bench/video_checker.sv
bench/video_tb.sv

//--- Makefile
# Verilator build of the video display testbench

TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = video_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = run.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the verdict, grep fails the target when the pass line is missing
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/video_tb.sv
`timescale 1ns/1ps
`default_nettype none

module video_tb
  import video_timing_pkg::*;
  import video_pixel_pkg::*;
();

  localparam int H_BORDER  = 64;
  localparam int NUM_ROWS  = 4;
  localparam int CYC_LIMIT = (NUM_ROWS + 2) * V_TOTAL * H_TOTAL;  // rows plus slack

  logic     clk24 = 1'b0;
  logic     rst_n;
  scroll_t  scroll;
  rgb_t     fg_color;
  rgb_t     bg_color;
  rgb_t     border_color;
  fb_addr_t fb_addr;
  fb_byte_t fb_data = '0;
  fb_addr_t addr_hold = '0;  // address seen last clock
  logic     hsync;
  logic     vsync;
  logic     de;
  logic     retrace;
  rgb_t     rgb;
  int       check_count;
  int       error_count;
  int       frame_count;
  int       cycles = 0;
  int       seed;
  int       r;

  // stimulus table, one row per frame
  scroll_t  scroll_tab [NUM_ROWS];
  rgb_t     fg_tab     [NUM_ROWS];
  rgb_t     bg_tab     [NUM_ROWS];
  rgb_t     bd_tab     [NUM_ROWS];

  always #20 clk24 = ~clk24;  // 40 ns

  video_top #(.H_BORDER(H_BORDER)) i_video_top
  (
    .clk24        (clk24),
    .rst_n        (rst_n),
    .scroll       (scroll),
    .fg_color     (fg_color),
    .bg_color     (bg_color),
    .border_color (border_color),
    .fb_addr      (fb_addr),
    .fb_data      (fb_data),
    .hsync        (hsync),
    .vsync        (vsync),
    .de           (de),
    .retrace      (retrace),
    .rgb          (rgb)
  );

  video_checker #(.H_BORDER(H_BORDER)) i_video_checker
  (
    .clk24        (clk24),
    .rst_n        (rst_n),
    .hsync        (hsync),
    .vsync        (vsync),
    .de           (de),
    .retrace      (retrace),
    .rgb          (rgb),
    .fb_addr      (fb_addr),
    .scroll       (scroll),
    .fg_color     (fg_color),
    .bg_color     (bg_color),
    .border_color (border_color),
    .check_count  (check_count),
    .error_count  (error_count),
    .frame_count  (frame_count)
  );

  // ----------------------------------------
  // framebuffer model, one clock read latency
  // ----------------------------------------
  always @(posedge clk24)
  begin
    #2;
    fb_data   = fb_byte_t'((int'(addr_hold) * 37 + 11) % 256);
    addr_hold = fb_addr;
  end

  // run limit
  always @(posedge clk24)
  begin
    cycles++;
    if (cycles >= CYC_LIMIT)
    begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic apply_row(input int row);
    scroll       = scroll_tab[row];
    fg_color     = fg_tab[row];
    bg_color     = bg_tab[row];
    border_color = bd_tab[row];
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial
  begin
    seed          = 24047;
    scroll_tab[0] = 8'h00;  // no scroll
    fg_tab[0]     = 8'hff;
    bg_tab[0]     = 8'h00;
    bd_tab[0]     = 8'h03;
    scroll_tab[1] = 8'h01;  // one byte row up
    fg_tab[1]     = 8'he0;
    bg_tab[1]     = 8'h1c;
    bd_tab[1]     = 8'h92;
    scroll_tab[2] = 8'hc5;  // wraps mid screen
    fg_tab[2]     = 8'h5a;
    bg_tab[2]     = 8'ha5;
    bd_tab[2]     = 8'h7f;
    scroll_tab[3] = scroll_t'($random(seed));
    fg_tab[3]     = rgb_t'($random(seed));
    bg_tab[3]     = rgb_t'($random(seed));
    bd_tab[3]     = rgb_t'($random(seed));

    rst_n = 1'b0;
    apply_row(0);
    repeat (4) @(posedge clk24);
    #2;
    rst_n = 1'b1;

    @(negedge vsync);  // row 0 frame starts
    for (r = 1; r <= NUM_ROWS; r++)
    begin
      @(negedge vsync);  // previous frame done, change inside the pulse
      @(posedge clk24);
      #2;
      if (r < NUM_ROWS)
        apply_row(r);
    end
    repeat (4) @(posedge clk24);  // let the checker close the last frame

    if (frame_count != NUM_ROWS)
      $display("only %0d of %0d frames were checked", frame_count, NUM_ROWS);
    $display("summary: %0d frames, %0d checks, %0d errors", frame_count, check_count, error_count);
    if ((frame_count == NUM_ROWS) && (error_count == 0) && (check_count > 0))
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/video_checker.sv
`timescale 1ns/1ps
`default_nettype none

module video_checker
  import video_timing_pkg::*;
  import video_pixel_pkg::*;
#(
  parameter int H_BORDER = 64
)
(
  input  wire           clk24,
  input  wire           rst_n,
  input  wire           hsync,
  input  wire           vsync,
  input  wire           de,
  input  wire           retrace,
  input  wire rgb_t     rgb,
  input  wire fb_addr_t fb_addr,
  input  wire scroll_t  scroll,
  input  wire rgb_t     fg_color,
  input  wire rgb_t     bg_color,
  input  wire rgb_t     border_color,
  output int            check_count,
  output int            error_count,
  output int            frame_count
);

  localparam int NUM_TESTS = 5;

  string    test_name [NUM_TESTS];
  int       frame_chk [NUM_TESTS];  // per frame, per test
  int       frame_err [NUM_TESTS];
  logic     hs_q;
  logic     vs_q;
  logic     de_q;
  logic     frame_open;   // first vsync fall seen
  logic     line_open;    // first hsync fall seen
  logic     line_had_de;
  logic     ret_start;    // retrace at line start
  int       h_clk;        // clocks since hsync fall
  int       hs_low;
  int       vs_low;
  int       line_cnt;     // hsync falls since vsync fall
  int       de_lines;     // de line index in frame
  int       de_run;       // x within de
  int       addr_idx;     // reads seen on this line
  scroll_t  scroll_f;
  fb_addr_t addr_prev;

  initial
  begin
    test_name[0] = "horizontal timing";
    test_name[1] = "vertical timing";
    test_name[2] = "border and blank";
    test_name[3] = "screen pixels";
    test_name[4] = "scroll and doubling";
  end

  // ----------------------------------------
  // expected values
  // ----------------------------------------
  function automatic fb_byte_t model_byte(input int addr);
    return fb_byte_t'((addr * 37 + 11) % 256);  // same data the memory holds
  endfunction

  // byte row for screen line s, scroll then a 1, counting down
  function automatic int row_byte(input int s);
    return ((int'(scroll_f) * 2 + 1 - s + V_SCREEN) % V_SCREEN) / 2;
  endfunction

  function automatic bit screen_line(input int line);
    return (line >= V_BORDER) && (line < V_BORDER + V_SCREEN);
  endfunction

  function automatic bit is_screen(input int line, input int x);
    return screen_line(line) && (x >= H_BORDER) && (x < H_ACTIVE - H_BORDER);
  endfunction

  function automatic rgb_t expect_rgb(input int line, input int x);
    int       c;
    int       k;
    fb_byte_t b;
    if (!is_screen(line, x))
      return border_color;
    c = (x - H_BORDER) / COL_CLOCKS;
    k = ((x - H_BORDER) % COL_CLOCKS) / 2;  // 2 clocks per pixel
    b = model_byte(c * 256 + row_byte(line - V_BORDER));
    return b[7 - k] ? fg_color : bg_color;   // msb first
  endfunction

  task automatic score(input int test, input int got, input int expected, input string what);
    frame_chk[test]++;
    check_count++;
    if (got != expected)
    begin
      frame_err[test]++;
      error_count++;
      $display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  task automatic clear_frame();
    int t;
    for (t = 0; t < NUM_TESTS; t++)
    begin
      frame_chk[t] = 0;
      frame_err[t] = 0;
    end
  endtask

  task automatic report_frame();
    int t;
    for (t = 0; t < NUM_TESTS; t++)
      $display("frame %0d scroll %0d  %s: %0d checks, %0d errors",
               frame_count, scroll_f, test_name[t], frame_chk[t], frame_err[t]);
  endtask

  // ----------------------------------------
  // sampled mid-cycle, outputs settled
  // ----------------------------------------
  always @(negedge clk24)
  begin
    if (!rst_n)
    begin
      hs_q       = 1'b1;
      vs_q       = 1'b1;
      de_q       = 1'b0;
      frame_open = 1'b0;
      line_open  = 1'b0;
      addr_prev  = '0;
    end
    else
    begin
      if (hs_q && !hsync)  // line boundary
      begin
        if (line_open)
        begin
          score(0, h_clk, H_TOTAL, "hsync period");
          if (frame_open)
            score(1, int'(ret_start), int'(!line_had_de), "retrace on line");
        end
        line_open   = 1'b1;
        line_had_de = 1'b0;
        ret_start   = retrace;  // retrace is not delayed like de
        h_clk       = 0;
        hs_low      = 0;
        line_cnt++;
      end
      if (!hs_q && hsync && line_open)
        score(0, hs_low, H_SYNC, "hsync low clocks");

      if (vs_q && !vsync)  // frame boundary
      begin
        if (frame_open)
        begin
          score(1, line_cnt, V_TOTAL, "lines per frame");
          score(1, de_lines, V_ACTIVE, "de lines per frame");
          frame_count++;
          report_frame();
        end
        clear_frame();
        frame_open = 1'b1;
        line_cnt   = 0;
        de_lines   = 0;
        vs_low     = 0;
      end
      if (!vs_q && vsync && frame_open)
        score(1, vs_low, V_SYNC * H_TOTAL, "vsync low clocks");

      if (de && !de_q)
      begin
        line_had_de = 1'b1;
        de_run      = 0;
        addr_idx    = 0;
        if (de_lines == 0)
          scroll_f = scroll;  // stable since vsync
      end

      if (frame_open)
      begin
        if (de)
        begin
          if (is_screen(de_lines, de_run))
            score(3, rgb, expect_rgb(de_lines, de_run), "screen rgb");
          else
            score(2, rgb, expect_rgb(de_lines, de_run), "border rgb");
          if (fb_addr != addr_prev)  // a new read on the bus
            addr_idx++;
          if (is_screen(de_lines, de_run)
              && ((de_run - H_BORDER) % COL_CLOCKS == COL_CLOCKS / 2))
            score(4, fb_addr,
                  (de_run - H_BORDER) / COL_CLOCKS * 256 + row_byte(de_lines - V_BORDER),
                  "fb_addr");  // column address held mid column
          de_run++;
        end
        else
        begin
          score(2, rgb, 0, "rgb outside de");
          if (de_q)  // de just ended
          begin
            score(0, de_run, H_ACTIVE, "de clocks per line");
            if (!screen_line(de_lines))
              score(4, addr_idx, 0, "reads on border line");
            de_lines++;
          end
        end
      end

      hs_q      = hsync;
      vs_q      = vsync;
      de_q      = de;
      addr_prev = fb_addr;
      h_clk++;
      if (!hsync)
        hs_low++;
      if (!vsync)
        vs_low++;
    end
  end

endmodule

`default_nettype wire

//--- verilog/video_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_top
  import video_timing_pkg::*;
  import video_pixel_pkg::*;
#(
  parameter int H_BORDER = 64   // side border in clocks
)
(
  input  wire            clk24,
  input  wire            rst_n,
  input  wire scroll_t   scroll,
  input  wire rgb_t      fg_color,
  input  wire rgb_t      bg_color,
  input  wire rgb_t      border_color,
  output fb_addr_t       fb_addr,
  input  wire fb_byte_t  fb_data,
  output logic           hsync,
  output logic           vsync,
  output logic           de,
  output logic           retrace,
  output rgb_t           rgb
);

  // raster to fetch and shifter
  px_count_t pix_x;
  fb_row_t   fb_row;
  logic      active_x;
  logic      active_y;
  logic      border_y;
  logic      hsync_r;
  logic      vsync_r;
  logic      line_start;

  // fetch to shifter
  fb_byte_t  fb_byte;
  logic      load;

  raster_timing i_raster_timing
  (
    .clk24      (clk24),
    .rst_n      (rst_n),
    .scroll     (scroll),
    .hsync_r    (hsync_r),
    .vsync_r    (vsync_r),
    .active_x   (active_x),
    .active_y   (active_y),
    .border_y   (border_y),
    .retrace    (retrace),
    .line_start (line_start),
    .pix_x      (pix_x),
    .fb_row     (fb_row)
  );

  fb_fetch #(.H_BORDER(H_BORDER)) i_fb_fetch
  (
    .clk24    (clk24),
    .rst_n    (rst_n),
    .pix_x    (pix_x),
    .active_x (active_x),
    .active_y (active_y),
    .border_y (border_y),
    .fb_row   (fb_row),
    .fb_addr  (fb_addr),
    .fb_data  (fb_data),
    .fb_byte  (fb_byte),
    .load     (load)
  );

  pixel_shifter #(.H_BORDER(H_BORDER)) i_pixel_shifter
  (
    .clk24        (clk24),
    .rst_n        (rst_n),
    .fb_byte      (fb_byte),
    .load         (load),
    .pix_x        (pix_x),
    .active_x     (active_x),
    .active_y     (active_y),
    .border_y     (border_y),
    .hsync_r      (hsync_r),
    .vsync_r      (vsync_r),
    .fg_color     (fg_color),
    .bg_color     (bg_color),
    .border_color (border_color),
    .hsync        (hsync),
    .vsync        (vsync),
    .de           (de),
    .rgb          (rgb)
  );

endmodule

`default_nettype wire

//--- verilog/pixel_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_shifter
  import video_timing_pkg::*;
  import video_pixel_pkg::*;
#(
  parameter int H_BORDER = 64   // even, so pixel pairs start on even pix_x
)
(
  input  wire            clk24,
  input  wire            rst_n,
  input  wire fb_byte_t  fb_byte,
  input  wire            load,
  input  wire px_count_t pix_x,
  input  wire            active_x,
  input  wire            active_y,
  input  wire            border_y,
  input  wire            hsync_r,
  input  wire            vsync_r,
  input  wire rgb_t      fg_color,
  input  wire rgb_t      bg_color,
  input  wire rgb_t      border_color,
  output logic           hsync,
  output logic           vsync,
  output logic           de,
  output rgb_t           rgb
);

  fb_byte_t shift_q;    // msb is the pixel on screen
  logic     cur_bit;
  logic     edge_col;   // left or right border column
  logic     s1_de;
  logic     s1_hs;
  logic     s1_vs;
  logic     s1_border;
  logic     s1_bit;

  // load clock shows bit 7 straight from the fetch register
  assign cur_bit  = load ? fb_byte[7] : shift_q[7];
  assign edge_col = (pix_x < px_count_t'(H_BORDER))
                 || (pix_x >= px_count_t'(H_ACTIVE - H_BORDER));

  // ----------------------------------------
  // shifter, one bit per two clocks
  // ----------------------------------------
  always_ff @(posedge clk24)
  begin
    if (load)
      shift_q <= fb_byte;
    else if (pix_x[0])
      shift_q <= {shift_q[6:0], 1'b0};  // second clock of a pixel
  end

  // stage 1, position + 1
  always_ff @(posedge clk24)
  begin
    if (!rst_n)
    begin
      s1_de <= 1'b0;
      s1_hs <= 1'b1;
      s1_vs <= 1'b1;
    end
    else
    begin
      s1_de <= active_x && active_y;
      s1_hs <= hsync_r;
      s1_vs <= vsync_r;
    end
  end

  always_ff @(posedge clk24)
  begin
    s1_border <= border_y || edge_col;
    s1_bit    <= cur_bit;
  end

  // ----------------------------------------
  // stage 2, colour select, position + 2
  // ----------------------------------------
  always_ff @(posedge clk24)
  begin
    if (!rst_n)
    begin
      hsync <= 1'b1;
      vsync <= 1'b1;
      de    <= 1'b0;
      rgb   <= '0;
    end
    else
    begin
      hsync <= s1_hs;
      vsync <= s1_vs;
      de    <= s1_de;
      if (!s1_de)
        rgb <= '0;              // blank
      else if (s1_border)
        rgb <= border_color;
      else if (s1_bit)
        rgb <= fg_color;
      else
        rgb <= bg_color;
    end
  end

endmodule

`default_nettype wire

//--- verilog/fb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fb_fetch
  import video_timing_pkg::*;
  import video_pixel_pkg::*;
#(
  parameter int H_BORDER = 64
)
(
  input  wire            clk24,
  input  wire            rst_n,
  input  wire px_count_t pix_x,
  input  wire            active_x,
  input  wire            active_y,
  input  wire            border_y,
  input  wire fb_row_t   fb_row,
  output fb_addr_t       fb_addr,
  input  wire fb_byte_t  fb_data,   // valid the clock after fb_addr
  output fb_byte_t       fb_byte,
  output logic           load       // fb_byte ready, first clock of column
);

  // decode one clock before the slot since fb_addr is registered
  localparam px_count_t FIRST_DEC = px_count_t'(H_BORDER - 3);
  localparam px_count_t SLOT_SPAN = px_count_t'(SCREEN_COLS * COL_CLOCKS);

  px_count_t rel_x;       // offset from first decode point
  column_t   col;
  logic      screen_line;
  logic      dec_hit;
  logic      rd_q;        // address on the bus this clock
  logic      data_vld;    // fb_data valid this clock

  assign screen_line = active_y && !border_y;
  assign rel_x       = pix_x - FIRST_DEC;
  assign col         = rel_x[8:4];

  assign dec_hit = screen_line && active_x
                && (pix_x >= FIRST_DEC)
                && (rel_x < SLOT_SPAN)
                && (rel_x[3:0] == 4'd0);   // one per 16 clocks

  // ----------------------------------------
  // read address and strobes
  // ----------------------------------------
  always_ff @(posedge clk24)
  begin
    if (!rst_n)
    begin
      fb_addr  <= '0;
      rd_q     <= 1'b0;
      data_vld <= 1'b0;
      load     <= 1'b0;
    end
    else
    begin
      if (dec_hit)
        fb_addr <= {col, fb_row[8:1]};  // byte row drops the doubling bit
      rd_q     <= dec_hit;   // at H_BORDER + 16c - 2
      data_vld <= rd_q;      // byte arrives
      load     <= data_vld;  // at H_BORDER + 16c
    end
  end

  // capture the returned byte
  always_ff @(posedge clk24)
  begin
    if (data_vld)
      fb_byte <= fb_data;
  end

endmodule

`default_nettype wire

//--- verilog/raster_timing.sv
`timescale 1ns/1ps
`default_nettype none

module raster_timing
  import video_timing_pkg::*;
(
  input  wire         clk24,
  input  wire         rst_n,
  input  wire scroll_t scroll,      // vertical scroll, taken once a frame
  output logic        hsync_r,      // active low
  output logic        vsync_r,      // active low
  output logic        active_x,
  output logic        active_y,
  output logic        border_y,     // top or bottom border line
  output logic        retrace,
  output logic        line_start,   // first clock of each line
  output px_count_t   pix_x,        // 0..639 across the visible area
  output fb_row_t     fb_row
);

  typedef enum logic [1:0]
  {
    H_FRONT_ST,
    H_SYNC_ST,
    H_BACK_ST,
    H_VIS_ST
  } h_state_t;

  typedef enum logic [2:0]
  {
    V_FRONT_ST,
    V_SYNC_ST,
    V_BACK_ST,
    V_TOP_ST,
    V_SCREEN_ST,
    V_BOTTOM_ST
  } v_state_t;

  h_state_t    h_state;
  px_count_t   h_cnt;     // clocks left in h state, minus one
  v_state_t    v_state;
  line_count_t v_cnt;     // lines left in v state, minus one
  scroll_t     scroll_q;  // frame copy of scroll
  logic        h_last;
  logic        v_last;

  assign h_last = (h_cnt == '0);
  assign v_last = (v_cnt == '0);

  // ----------------------------------------
  // horizontal machine
  // ----------------------------------------
  always_ff @(posedge clk24)
  begin
    if (!rst_n)
    begin
      h_state <= H_FRONT_ST;
      h_cnt   <= px_count_t'(H_FRONT - 1);
    end
    else if (h_last)
    begin
      case (h_state)
        H_FRONT_ST:
        begin
          h_state <= H_SYNC_ST;
          h_cnt   <= px_count_t'(H_SYNC - 1);
        end
        H_SYNC_ST:
        begin
          h_state <= H_BACK_ST;
          h_cnt   <= px_count_t'(H_BACK - 1);
        end
        H_BACK_ST:
        begin
          h_state <= H_VIS_ST;
          h_cnt   <= px_count_t'(H_ACTIVE - 1);
        end
        default:  // visible area done, wrap to next line
        begin
          h_state <= H_FRONT_ST;
          h_cnt   <= px_count_t'(H_FRONT - 1);
        end
      endcase
    end
    else
      h_cnt <= h_cnt - 1'b1;
  end

  // line pulse and visible x position
  always_ff @(posedge clk24)
  begin
    if (!rst_n)
    begin
      line_start <= 1'b0;
      pix_x      <= '0;
    end
    else
    begin
      line_start <= (h_state == H_VIS_ST) && h_last;  // lands on front porch clock 0
      if ((h_state == H_VIS_ST) && !h_last)
        pix_x <= pix_x + 1'b1;
      else
        pix_x <= '0;  // parked at 0 ready for next visible area
    end
  end

  // ----------------------------------------
  // vertical machine, stepped per line
  // ----------------------------------------
  always_ff @(posedge clk24)
  begin
    if (!rst_n)
    begin
      v_state <= V_FRONT_ST;
      v_cnt   <= line_count_t'(V_FRONT - 1);
    end
    else if (line_start)
    begin
      if (v_last)
      begin
        case (v_state)
          V_FRONT_ST:
          begin
            v_state <= V_SYNC_ST;
            v_cnt   <= line_count_t'(V_SYNC - 1);
          end
          V_SYNC_ST:
          begin
            v_state <= V_BACK_ST;
            v_cnt   <= line_count_t'(V_BACK - 1);
          end
          V_BACK_ST:
          begin
            v_state <= V_TOP_ST;
            v_cnt   <= line_count_t'(V_BORDER - 1);
          end
          V_TOP_ST:
          begin
            v_state <= V_SCREEN_ST;
            v_cnt   <= line_count_t'(V_SCREEN - 1);
          end
          V_SCREEN_ST:
          begin
            v_state <= V_BOTTOM_ST;
            v_cnt   <= line_count_t'(V_BORDER - 1);
          end
          default:  // bottom border, back to front porch
          begin
            v_state <= V_FRONT_ST;
            v_cnt   <= line_count_t'(V_FRONT - 1);
          end
        endcase
      end
      else
        v_cnt <= v_cnt - 1'b1;
    end
  end

  // scroll capture on entry to top border
  always_ff @(posedge clk24)
  begin
    if (line_start && v_last && (v_state == V_BACK_ST))
      scroll_q <= scroll;
  end

  // scan row counter, counts down so each byte row covers two lines
  always_ff @(posedge clk24)
  begin
    if (!rst_n)
      fb_row <= '0;
    else if (line_start)
    begin
      if (v_last && (v_state == V_TOP_ST))
        fb_row <= {scroll_q, 1'b1};      // first screen line
      else if (v_state == V_SCREEN_ST)
        fb_row <= fb_row - 1'b1;         // wraps mod 512
    end
  end

  // ----------------------------------------
  // decoded outputs
  // ----------------------------------------
  assign hsync_r  = (h_state != H_SYNC_ST);
  assign vsync_r  = (v_state != V_SYNC_ST);
  assign active_x = (h_state == H_VIS_ST);
  assign border_y = (v_state == V_TOP_ST) || (v_state == V_BOTTOM_ST);
  assign active_y = border_y || (v_state == V_SCREEN_ST);
  assign retrace  = !active_y;

endmodule

`default_nettype wire

//--- verilog/video_pixel_pkg.sv
`default_nettype none

package video_pixel_pkg;

  // colour, packed r3 g3 b2
  typedef logic [7:0] rgb_t;

  // framebuffer port
  typedef logic [12:0] fb_addr_t;  // {column, byte row}
  typedef logic [7:0]  fb_byte_t;  // eight pixels, msb leftmost
  typedef logic [4:0]  column_t;   // byte column 0..31

  localparam int SCREEN_COLS = 32;  // bytes per screen line
  localparam int COL_CLOCKS  = 16;  // 8 pixels x 2 clocks

endpackage

`default_nettype wire

//--- verilog/video_timing_pkg.sv
`default_nettype none

package video_timing_pkg;

  // ----------------------------------------
  // raster widths
  // ----------------------------------------
  typedef logic [9:0] px_count_t;    // clock position within a line
  typedef logic [9:0] line_count_t;  // line count within a frame
  typedef logic [8:0] fb_row_t;      // scan row, [8:1] is the byte row
  typedef logic [7:0] scroll_t;      // vertical scroll register

  // ----------------------------------------
  // horizontal timing, in clk24 clocks
  // ----------------------------------------
  localparam int H_FRONT  = 11;
  localparam int H_SYNC   = 56;   // hsync low
  localparam int H_BACK   = 61;
  localparam int H_ACTIVE = 640;  // visible clocks incl. side borders
  localparam int H_TOTAL  = H_FRONT + H_SYNC + H_BACK + H_ACTIVE;  // 768

  // ----------------------------------------
  // vertical timing, in lines
  // ----------------------------------------
  localparam int V_FRONT  = 21;
  localparam int V_SYNC   = 5;    // vsync low
  localparam int V_BACK   = 22;
  localparam int V_BORDER = 32;   // top and bottom border each
  localparam int V_SCREEN = 512;  // 256 byte rows, each shown twice

  localparam int V_ACTIVE = 2 * V_BORDER + V_SCREEN;  // 576
  localparam int V_TOTAL  = V_FRONT + V_SYNC + V_BACK + V_ACTIVE;  // 624

endpackage

`default_nettype wire
